// File: design/memSystem_cfg.svh
/*
 memory subsystem configuration
 RAM depth and latency, cache line counts
 */
`ifndef MEMSYSTEM_CFG_SVH
`define MEMSYSTEM_CFG_SVH

// RAM depth in 32-bit words
`define RAM_WORDS 1024

// BUSY cycles before ACCESS
`define RAM_LAT 3

// direct-mapped line counts, one word per line
`define ICACHE_SETS 8
`define DCACHE_SETS 8

`endif

// File: design/cpuTypesPkg.sv
/*
 cpu types package
 word, byte address and RAM state types shared by caches, controller and RAM
 */
package cpuTypesPkg;

   // data or instruction word
   typedef logic [31:0] word_t;

   // byte address
   // bits 1:0 ignored, accesses are word aligned
   typedef logic [31:0] addr_t;

   // RAM progress as seen by the controller
   // FREE    ready for a new request
   // BUSY    latency counting
   // ACCESS  read word valid / write committed
   // ERROR   address beyond RAM depth
   typedef enum logic [1:0] {
      FREE   = 2'd0,
      BUSY   = 2'd1,
      ACCESS = 2'd2,
      ERROR  = 2'd3
   } ramState_t;

endpackage

// File: design/iCache.sv
/*
 instruction cache
 direct-mapped, read-only, one word per line, refills through the controller
 */
`timescale 1ns/1ps
`include "memSystem_cfg.svh"

module iCache (
   input  logic                   CLK,
   input  logic                   rstN,
   input  logic                   iRen,
   input  cpuTypesPkg::addr_t     iAddr,
   output logic                   iHit,
   output cpuTypesPkg::word_t     iInstr,
   output logic                   cacheIRen,
   output cpuTypesPkg::addr_t     cacheIAddr,
   input  logic                   iWait,
   input  cpuTypesPkg::word_t     iLoad,
   input  cpuTypesPkg::ramState_t ramState
);
   import cpuTypesPkg::*;

   localparam int idxW = $clog2(`ICACHE_SETS);
   localparam int tagW = 30 - idxW;

   // line storage
   logic [`ICACHE_SETS-1:0] valid;
   logic [tagW-1:0]         tags [`ICACHE_SETS];
   word_t                   words [`ICACHE_SETS];

   logic [idxW-1:0] idx;
   logic [tagW-1:0] tag;
   logic            fill;
   logic            fillDone;

   // index right above the word offset, tag is the rest
   assign idx = iAddr[idxW+1:2];
   assign tag = iAddr[31:idxW+2];

   // combinational hit, only while fetching
   assign iHit   = iRen && valid[idx] && (tags[idx] == tag);
   assign iInstr = words[idx];

   // refill request on miss
   // quiet for one cycle after a fill
   assign cacheIRen  = iRen && !iHit && !fillDone;
   assign cacheIAddr = {iAddr[31:2], 2'b00};

   // wait low alone is not enough, the RAM must be in ACCESS
   assign fill = cacheIRen && !iWait && (ramState == ACCESS);

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         valid    <= '0;
         fillDone <= 1'b0;
      end else begin
         fillDone <= fill;
         if (fill) begin
            valid[idx] <= 1'b1;
         end
      end
   end

   // tag and word written with the fill
   always_ff @(posedge CLK) begin
      if (fill) begin
         tags[idx]  <= tag;
         words[idx] <= iLoad;
      end
   end

endmodule

// File: design/dCache.sv
/*
 data cache
 direct-mapped write-through, no write-allocate, one word per line
 */
`timescale 1ns/1ps
`include "memSystem_cfg.svh"

module dCache (
   input  logic                   CLK,
   input  logic                   rstN,
   input  logic                   dRen,
   input  logic                   dWen,
   input  cpuTypesPkg::addr_t     dAddr,
   input  cpuTypesPkg::word_t     dStore,
   output logic                   dHit,
   output cpuTypesPkg::word_t     dLoad,
   output logic                   cacheDRen,
   output logic                   cacheDWen,
   output cpuTypesPkg::addr_t     cacheDAddr,
   output cpuTypesPkg::word_t     cacheDStore,
   input  logic                   dWait,
   input  cpuTypesPkg::word_t     memLoad,
   input  cpuTypesPkg::ramState_t ramState
);
   import cpuTypesPkg::*;

   localparam int idxW = $clog2(`DCACHE_SETS);
   localparam int tagW = 30 - idxW;

   typedef enum logic [1:0] {
      stIdle = 2'd0,
      stPend = 2'd1,
      stDone = 2'd2
   } dState_t;

   // line storage
   logic [`DCACHE_SETS-1:0] valid;
   logic [tagW-1:0]         tags [`DCACHE_SETS];
   word_t                   words [`DCACHE_SETS];

   dState_t         state;
   dState_t         nextState;
   logic [idxW-1:0] idx;
   logic [tagW-1:0] tag;
   logic            lineHit;
   logic            memDone;

   assign idx     = dAddr[idxW+1:2];
   assign tag     = dAddr[31:idxW+2];
   assign lineHit = valid[idx] && (tags[idx] == tag);

   // read misses and all writes go to memory
   // nothing new is issued in the done cycle
   assign cacheDRen   = dRen && !lineHit && (state != stDone);
   assign cacheDWen   = dWen && (state != stDone);
   assign cacheDAddr  = {dAddr[31:2], 2'b00};
   assign cacheDStore = dStore;

   // access finished when selected and the RAM reports ACCESS
   assign memDone = (cacheDRen || cacheDWen) && !dWait && (ramState == ACCESS);

   // read hit is combinational
   // write hit waits for the RAM commit
   assign dHit  = (dRen && lineHit) || (dWen && (state == stDone));
   assign dLoad = words[idx];

   always_comb begin
      case (state)
         stIdle, stPend: begin
            if (memDone) begin
               nextState = stDone;
            end else if (cacheDRen || cacheDWen) begin
               nextState = stPend;
            end else begin
               nextState = stIdle;
            end
         end
         default: nextState = stIdle;
      endcase
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
         valid <= '0;
      end else begin
         state <= nextState;
         // only a read miss allocates
         if (memDone && cacheDRen) begin
            valid[idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (memDone && cacheDRen) begin
         tags[idx]  <= tag;
         words[idx] <= memLoad;
      end else if (memDone && cacheDWen && lineHit) begin
         // write hit keeps the line coherent with RAM
         words[idx] <= dStore;
      end
   end

endmodule

// File: design/memoryControl.sv
/*
 memory controller
 fixed-priority arbiter, data over instruction, onto the single RAM port
 */
`timescale 1ns/1ps

module memoryControl (
   input  logic                   CLK,
   input  logic                   rstN,
   // instruction cache side
   input  logic                   cacheIRen,
   input  cpuTypesPkg::addr_t     cacheIAddr,
   output logic                   iWait,
   output cpuTypesPkg::word_t     iLoad,
   // data cache side
   input  logic                   cacheDRen,
   input  logic                   cacheDWen,
   input  cpuTypesPkg::addr_t     cacheDAddr,
   input  cpuTypesPkg::word_t     cacheDStore,
   output logic                   dWait,
   output cpuTypesPkg::word_t     dLoad,
   // RAM side
   output logic                   ramRen,
   output logic                   ramWen,
   output cpuTypesPkg::addr_t     ramAddr,
   output cpuTypesPkg::word_t     ramStore,
   input  cpuTypesPkg::word_t     ramLoad,
   input  cpuTypesPkg::ramState_t ramState
);
   import cpuTypesPkg::*;

   localparam logic [1:0] selNone  = 2'd0;
   localparam logic [1:0] selData  = 2'd1;
   localparam logic [1:0] selInstr = 2'd2;

   logic       dReq;
   logic       iReq;
   logic [1:0] prioGrant;
   logic [1:0] grant;
   logic [1:0] selReg;

   assign dReq = cacheDRen || cacheDWen;
   assign iReq = cacheIRen;

   // data first, then instruction
   always_comb begin
      if (dReq) begin
         prioGrant = selData;
      end else if (iReq) begin
         prioGrant = selInstr;
      end else begin
         prioGrant = selNone;
      end
   end

   // an access in flight keeps its owner
   assign grant = (selReg != selNone) ? selReg : prioGrant;

   always_comb begin
      ramRen  = 1'b0;
      ramWen  = 1'b0;
      ramAddr = cacheIAddr;
      // pending but not selected, hold off
      dWait   = dReq;
      iWait   = iReq;
      case (grant)
         selData: begin
            ramRen  = cacheDRen;
            ramWen  = cacheDWen;
            ramAddr = cacheDAddr;
            dWait   = dReq && (ramState != ACCESS);
         end
         selInstr: begin
            ramRen = cacheIRen;
            iWait  = iReq && (ramState != ACCESS);
         end
         default: begin
            ramRen = 1'b0;
         end
      endcase
   end

   // both caches see the RAM word, only dCache stores
   assign dLoad    = ramLoad;
   assign iLoad    = ramLoad;
   assign ramStore = cacheDStore;

   // owner latched when the RAM takes a request
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         selReg <= selNone;
      end else if ((ramState == ACCESS) || (ramState == ERROR)) begin
         selReg <= selNone;
      end else if ((ramState == FREE) && (ramRen || ramWen)) begin
         selReg <= grant;
      end
   end

endmodule

// File: design/ramModel.sv
/*
 RAM model
 word array with fixed BUSY latency, one ACCESS cycle, then FREE
 */
`timescale 1ns/1ps
`include "memSystem_cfg.svh"

module ramModel (
   input  logic                   CLK,
   input  logic                   rstN,
   input  logic                   ramRen,
   input  logic                   ramWen,
   input  cpuTypesPkg::addr_t     ramAddr,
   input  cpuTypesPkg::word_t     ramStore,
   output cpuTypesPkg::word_t     ramLoad,
   output cpuTypesPkg::ramState_t ramState
);
   import cpuTypesPkg::*;

   localparam int idxW = $clog2(`RAM_WORDS);
   localparam int cntW = $clog2(`RAM_LAT + 1);

   word_t           mem [`RAM_WORDS];
   ramState_t       state;
   logic [cntW-1:0] latCnt;
   logic [idxW-1:0] addrLat;
   logic            wenLat;
   logic            badLat;
   logic            inRange;

   // word index checked against depth
   assign inRange  = (ramAddr[31:2] < 30'(`RAM_WORDS));
   assign ramState = state;
   // read word only during ACCESS
   assign ramLoad  = ((state == ACCESS) && !wenLat) ? mem[addrLat] : '0;

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         state   <= FREE;
         latCnt  <= '0;
         addrLat <= '0;
         wenLat  <= 1'b0;
         badLat  <= 1'b0;
         for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else begin
         case (state)
            FREE: begin
               // new requests only taken here
               if (ramRen || ramWen) begin
                  state   <= BUSY;
                  latCnt  <= cntW'(`RAM_LAT - 1);
                  addrLat <= ramAddr[idxW+1:2];
                  wenLat  <= ramWen;
                  badLat  <= !inRange;
               end
            end
            BUSY: begin
               if (latCnt == '0) begin
                  state <= badLat ? ERROR : ACCESS;
               end else begin
                  latCnt <= latCnt - 1'b1;
               end
            end
            ACCESS: begin
               // write commits at the ACCESS edge
               if (wenLat) begin
                  mem[addrLat] <= ramStore;
               end
               state <= FREE;
            end
            default: state <= FREE;
         endcase
      end
   end

endmodule

// File: design/memSystem.sv
/*
 memory subsystem top
 instruction and data caches, controller and RAM model
 */
`timescale 1ns/1ps

module memSystem (
   input  logic               CLK,
   input  logic               rstN,
   input  logic               iRen,
   input  logic               dRen,
   input  logic               dWen,
   input  cpuTypesPkg::addr_t iAddr,
   input  cpuTypesPkg::addr_t dAddr,
   input  cpuTypesPkg::word_t dStore,
   output logic               iHit,
   output logic               dHit,
   output cpuTypesPkg::word_t iInstr,
   output cpuTypesPkg::word_t dLoad
);
   import cpuTypesPkg::*;

   // cache to controller
   logic      cacheIRen;
   addr_t     cacheIAddr;
   logic      iWait;
   word_t     iLoad;
   logic      cacheDRen;
   logic      cacheDWen;
   addr_t     cacheDAddr;
   word_t     cacheDStore;
   logic      dWait;
   word_t     memDLoad;

   // controller to RAM
   logic      ramRen;
   logic      ramWen;
   addr_t     ramAddr;
   word_t     ramStore;
   word_t     ramLoad;
   ramState_t ramState;

   iCache icache (.*);

   dCache dcache (
      .*,
      .memLoad (memDLoad)
   );

   memoryControl memCtrl (
      .*,
      .dLoad (memDLoad)
   );

   ramModel ram (.*);

endmodule

// File: tb/memSystem_tb.sv
/*
 memory subsystem testbench
 random processor traffic checked against a memory model and an instruction-cache model
 */
`timescale 1ns/1ps
`include "memSystem_cfg.svh"

module memSystem_tb;
   import cpuTypesPkg::*;

   localparam int iIdxW    = $clog2(`ICACHE_SETS);
   localparam int memIdxW  = $clog2(`RAM_WORDS);
   localparam int hitLimit = 100;

   logic   CLK;
   logic   rstN;
   logic   iRen;
   logic   dRen;
   logic   dWen;
   addr_t  iAddr;
   addr_t  dAddr;
   word_t  dStore;
   logic   iHit;
   logic   dHit;
   word_t  iInstr;
   word_t  dLoad;
   integer seed;

   // reference state
   word_t             memModel [`RAM_WORDS];
   logic              iValid [`ICACHE_SETS];
   logic [29-iIdxW:0] iTag [`ICACHE_SETS];
   word_t             iWord [`ICACHE_SETS];

   memSystem UUT (.*);

   always #10 CLK = ~CLK;

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         abortRun($sformatf("FAILED at %0t: %s expected %h got %h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         abortRun($sformatf("FAILED at %0t: %s expected %b got %b",
                            $time, name, expected, actual));
      end
   endtask

   function automatic logic [memIdxW-1:0] memIdx(input addr_t a);
      return a[memIdxW+1:2];
   endfunction

   // one of 32 words, so indexes collide across 4 tags
   function automatic addr_t randAddr();
      return addr_t'(({$random(seed)} % 32) << 2);
   endfunction

   // icache lookup, a miss refills from the memory model
   function automatic word_t fetchModel(input addr_t a, output logic miss);
      logic [iIdxW-1:0]  idx;
      logic [29-iIdxW:0] tag;
      idx  = a[iIdxW+1:2];
      tag  = a[31:iIdxW+2];
      miss = !(iValid[idx] && (iTag[idx] == tag));
      if (miss) begin
         iValid[idx] = 1'b1;
         iTag[idx]   = tag;
         iWord[idx]  = memModel[memIdx(a)];
      end
      return iWord[idx];
   endfunction

   // issue either or both ports, hold each until its hit, then check
   task automatic runAccess(input logic doInstr, input addr_t iA, input logic doData,
                            input logic doWrite, input addr_t dA, input word_t wData,
                            output int iAt, output int dAt);
      word_t expI;
      word_t expD;
      word_t gotI;
      word_t gotD;
      logic  iMiss;
      logic  iDone;
      logic  dDone;
      int    n;
      iMiss = 1'b0;
      expI  = '0;
      gotI  = '0;
      gotD  = '0;
      iAt   = -1;
      dAt   = -1;
      // data wins arbitration, so a write lands before any instruction refill
      if (doData && doWrite) begin
         memModel[memIdx(dA)] = wData;
      end
      expD = memModel[memIdx(dA)];
      if (doInstr) begin
         expI = fetchModel(iA, iMiss);
      end
      iRen   = doInstr;
      iAddr  = iA;
      dRen   = doData && !doWrite;
      dWen   = doData && doWrite;
      dAddr  = dA;
      dStore = wData;
      iDone  = !doInstr;
      dDone  = !doData;
      n      = 0;
      while (!(iDone && dDone) && (n < hitLimit)) begin
         // mid-cycle, hits are settled
         @(negedge CLK);
         if (!iDone && iHit) begin
            iDone = 1'b1;
            iAt   = n;
            gotI  = iInstr;
         end
         if (!dDone && dHit) begin
            dDone = 1'b1;
            dAt   = n;
            gotD  = dLoad;
         end
         @(posedge CLK);
         #2;
         if (iDone) begin
            iRen = 1'b0;
         end
         if (dDone) begin
            dRen = 1'b0;
            dWen = 1'b0;
         end
         n++;
      end
      if (!(iDone && dDone)) begin
         abortRun($sformatf("timeout: hit never came within %0d cycles (iAddr %h, dAddr %h)",
                            hitLimit, iA, dA));
      end
      if (doInstr) begin
         checkWord("iInstr", expI, gotI);
      end
      if (doData && !doWrite) begin
         checkWord("dLoad", expD, gotD);
      end
      // an instruction miss queues behind data
      if (doInstr && doData && iMiss) begin
         checkFlag("dHit not after iHit", 1'b1, dAt <= iAt);
      end
   endtask

   task automatic dataRead(input addr_t a, output int at);
      int unused;
      runAccess(1'b0, '0, 1'b1, 1'b0, a, '0, unused, at);
   endtask

   task automatic dataWrite(input addr_t a, input word_t w);
      int unused;
      runAccess(1'b0, '0, 1'b1, 1'b1, a, w, unused, unused);
   endtask

   task automatic instrFetch(input addr_t a, output int at);
      int unused;
      runAccess(1'b1, a, 1'b0, 1'b0, '0, '0, at, unused);
   endtask

   initial begin
      int    iAt;
      int    dAt;
      int    op;
      addr_t a;
      addr_t b;
      word_t w;
      CLK    = 1'b0;
      rstN   = 1'b0;
      iRen   = 1'b0;
      dRen   = 1'b0;
      dWen   = 1'b0;
      iAddr  = '0;
      dAddr  = '0;
      dStore = '0;
      seed   = 32'h679b;
      for (int i = 0; i < `RAM_WORDS; i++) begin
         memModel[i] = '0;
      end
      for (int i = 0; i < `ICACHE_SETS; i++) begin
         iValid[i] = 1'b0;
      end
      repeat (2) @(posedge CLK);
      #2;
      rstN = 1'b1;
      checkFlag("iHit", 1'b0, iHit);
      checkFlag("dHit", 1'b0, dHit);
      @(posedge CLK);
      #2;

      // cleared RAM reads back zero
      repeat (4) begin
         dataRead(randAddr(), dAt);
      end

      // write, miss fill, then hit
      a = randAddr();
      w = $random(seed);
      dataWrite(a, w);
      dataRead(a, dAt);
      dataRead(a, dAt);
      checkFlag("dHit in request cycle", 1'b1, dAt == 0);
      // matching line updated in place
      w = $random(seed);
      dataWrite(a, w);
      dataRead(a, dAt);
      checkFlag("dHit in request cycle", 1'b1, dAt == 0);
      // conflict evicts, refill gives a lone miss latency
      dataRead(a ^ 32'h20, dAt);
      dataRead(a, dAt);
      checkFlag("dHit at miss latency", 1'b1, dAt == `RAM_LAT + 2);

      // icache ignores data writes until the line is replaced
      b = randAddr();
      instrFetch(b, iAt);
      w = $random(seed);
      dataWrite(b, w);
      instrFetch(b, iAt);
      checkFlag("iHit in request cycle", 1'b1, iAt == 0);
      instrFetch(b ^ 32'h20, iAt);
      instrFetch(b, iAt);

      // fetch and data access raised together
      runAccess(1'b1, 32'h400, 1'b1, 1'b0, randAddr(), '0, iAt, dAt);
      w = $random(seed);
      runAccess(1'b1, 32'h404, 1'b1, 1'b1, randAddr(), w, iAt, dAt);

      // long random mix
      repeat (300) begin
         op = {$random(seed)} % 4;
         a  = randAddr();
         b  = randAddr();
         w  = $random(seed);
         case (op)
            0: dataRead(a, dAt);
            1: dataWrite(a, w);
            2: instrFetch(b, iAt);
            default: runAccess(1'b1, b, 1'b1, w[0], a, w, iAt, dAt);
         endcase
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: tb.f
+incdir+design
design/cpuTypesPkg.sv
design/iCache.sv
design/dCache.sv
design/memoryControl.sv
design/ramModel.sv
design/memSystem.sv
tb/memSystem_tb.sv

// File: Bender.yml
package:
  name: memSystem

sources:
  - include_dirs:
      - design
    files:
      - design/cpuTypesPkg.sv
      - design/iCache.sv
      - design/dCache.sv
      - design/memoryControl.sv
      - design/ramModel.sv
      - design/memSystem.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/memSystem_tb.sv
